/* verilog/log_pkg.sv */
package log_pkg;

    // ------------------------------
    // Log word format
    // ------------------------------

    // Samples, headers and read data
    typedef logic [15:0] word_t;

    // Channels per frame
    localparam int N_ADC = 6;

    // Header word plus one sample per channel
    localparam int FRAME_LEN = N_ADC + 1;

    // Upper byte of a header word
    localparam logic [7:0] HDR_MARK = 8'hA5;

    // Lower byte of a header word
    typedef logic [7:0] seq_t;

    typedef logic [2:0] chan_t;

    // Framer FSM
    typedef enum logic [1:0] {
        FR_IDLE,
        FR_HOLD,
        FR_SAMPLE
    } framer_state_t;

endpackage

/* verilog/buf_pkg.sv */
package buf_pkg;

    // ------------------------------
    // Block buffer geometry
    // ------------------------------

    // Words per block
    localparam int BUF_DEPTH = 16;
    localparam int BUF_AW = 4;

    typedef logic [BUF_AW-1:0] buf_addr_t;

    // Address plus wrap bit, binary or Gray
    typedef logic [BUF_AW:0] buf_ptr_t;

    // Saturating drop counter
    typedef logic [15:0] drop_cnt_t;

    // Ping-pong bank select
    typedef enum logic {
        BANK0,
        BANK1
    } bank_t;

endpackage

/* verilog/log_buffer.sv */
`timescale 1ns/100ps

module log_buffer
    import log_pkg::*, buf_pkg::*;
(
    input  logic  wr_clk,
    input  logic  rd_clk,
    input  logic  rst,
    input  logic  we,
    input  word_t din,
    input  logic  re,
    output word_t dout,
    output logic  wr_full,
    output logic  wr_empty,
    output logic  rd_full
);

    function automatic buf_ptr_t to_gray(buf_ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

    function automatic buf_ptr_t to_bin(buf_ptr_t gray);
        buf_ptr_t bin;
        bin[BUF_AW] = gray[BUF_AW];
        for (int i = BUF_AW - 1; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

    word_t      mem [BUF_DEPTH];

    // Write domain
    buf_ptr_t   wr_ptr;
    buf_ptr_t   wr_ptr_gray;
    buf_ptr_t   rd_gray_meta;
    buf_ptr_t   rd_gray_sync;
    buf_ptr_t   rd_ptr_wr;
    buf_ptr_t   wr_cnt;
    buf_addr_t  wr_addr;
    logic       push;

    // Read domain
    logic [1:0] rd_rst_pipe;
    logic       rd_rst;
    buf_ptr_t   rd_ptr;
    buf_ptr_t   rd_ptr_gray;
    buf_ptr_t   wr_gray_meta;
    buf_ptr_t   wr_gray_sync;
    buf_ptr_t   wr_ptr_rd;
    buf_ptr_t   rd_cnt;
    buf_addr_t  rd_addr;
    logic       pop;

    // ------------------------------
    // Write side
    // ------------------------------

    assign wr_addr = wr_ptr[BUF_AW-1:0];
    assign push    = we && !wr_full;

    always_ff @(posedge wr_clk) begin
        if (rst) begin
            wr_ptr      <= '0;
            wr_ptr_gray <= '0;
        end else if (push) begin
            wr_ptr      <= wr_ptr + 1'b1;
            wr_ptr_gray <= to_gray(wr_ptr + 1'b1);
        end
    end

    always_ff @(posedge wr_clk) begin
        if (push) begin
            mem[wr_addr] <= din;
        end
    end

    // Read pointer into wr_clk
    always_ff @(posedge wr_clk) begin
        if (rst) begin
            rd_gray_meta <= '0;
            rd_gray_sync <= '0;
        end else begin
            rd_gray_meta <= rd_ptr_gray;
            rd_gray_sync <= rd_gray_meta;
        end
    end

    assign rd_ptr_wr = to_bin(rd_gray_sync);
    assign wr_cnt    = wr_ptr - rd_ptr_wr;

    // Full once a whole block sits in RAM, empty once the reader is done
    assign wr_full  = (wr_cnt == buf_ptr_t'(BUF_DEPTH));
    assign wr_empty = (wr_cnt == '0);

    // ------------------------------
    // Read side
    // ------------------------------

    // Two flop retime of rst
    always_ff @(posedge rd_clk) begin
        rd_rst_pipe <= {rd_rst_pipe[0], rst};
    end

    assign rd_rst = rd_rst_pipe[1];

    // Write pointer into rd_clk
    always_ff @(posedge rd_clk) begin
        if (rd_rst) begin
            wr_gray_meta <= '0;
            wr_gray_sync <= '0;
        end else begin
            wr_gray_meta <= wr_ptr_gray;
            wr_gray_sync <= wr_gray_meta;
        end
    end

    assign wr_ptr_rd = to_bin(wr_gray_sync);
    assign rd_cnt    = wr_ptr_rd - rd_ptr;
    assign rd_addr   = rd_ptr[BUF_AW-1:0];

    // Pops only count against a complete block
    assign pop = re && rd_full;

    always_ff @(posedge rd_clk) begin
        if (rd_rst) begin
            rd_ptr      <= '0;
            rd_ptr_gray <= '0;
        end else if (pop) begin
            rd_ptr      <= rd_ptr + 1'b1;
            rd_ptr_gray <= to_gray(rd_ptr + 1'b1);
        end
    end

    // Set on a complete block, cleared by the edge popping its last word
    always_ff @(posedge rd_clk) begin
        if (rd_rst) begin
            rd_full <= 1'b0;
        end else if (pop && rd_cnt == buf_ptr_t'(1)) begin
            rd_full <= 1'b0;
        end else if (rd_cnt == buf_ptr_t'(BUF_DEPTH)) begin
            rd_full <= 1'b1;
        end
    end

    // Registered read port, one cycle latency
    always_ff @(posedge rd_clk) begin
        if (rd_rst) begin
            dout <= '0;
        end else if (pop) begin
            dout <= mem[rd_addr];
        end
    end

endmodule

/* verilog/dual_log_fifo.sv */
`timescale 1ns/100ps

module dual_log_fifo
    import log_pkg::*, buf_pkg::*;
(
    input  logic      wr_clk,
    input  logic      rd_clk,
    input  logic      rst,
    input  logic      log_we,
    input  word_t     log_word,
    input  logic      rd_en,
    output logic      rd_rdy,
    output word_t     dout,
    output drop_cnt_t drop_cnt
);

    // Write side state
    bank_t      wr_bank;
    buf_addr_t  blk_cnt;
    logic       cur_full;
    logic       cur_empty;
    logic       accept;

    // Read side state
    logic [1:0] rd_rst_pipe;
    logic       rd_rst;
    bank_t      rd_bank;
    bank_t      dout_bank;
    logic       rd_rdy_q;
    logic       pop;

    // Bank wiring
    logic       buf0_we;
    logic       buf1_we;
    logic       buf0_re;
    logic       buf1_re;
    word_t      buf0_dout;
    word_t      buf1_dout;
    logic       buf0_wr_full;
    logic       buf1_wr_full;
    logic       buf0_wr_empty;
    logic       buf1_wr_empty;
    logic       buf0_rd_full;
    logic       buf1_rd_full;

    // ------------------------------
    // Write bank select
    // ------------------------------

    assign cur_full  = (wr_bank == BANK0) ? buf0_wr_full : buf1_wr_full;
    assign cur_empty = (wr_bank == BANK0) ? buf0_wr_empty : buf1_wr_empty;

    // New block only into a free bank, a started block runs to the end
    assign accept  = log_we && !cur_full && (cur_empty || blk_cnt != '0);
    assign buf0_we = accept && (wr_bank == BANK0);
    assign buf1_we = accept && (wr_bank == BANK1);

    always_ff @(posedge wr_clk) begin
        if (rst) begin
            wr_bank <= BANK0;
            blk_cnt <= '0;
        end else if (accept) begin
            // Wraps to zero on the last word of a block
            blk_cnt <= blk_cnt + 1'b1;
            if (blk_cnt == buf_addr_t'(BUF_DEPTH - 1)) begin
                wr_bank <= (wr_bank == BANK0) ? BANK1 : BANK0;
            end
        end
    end

    // Lost words, saturating
    always_ff @(posedge wr_clk) begin
        if (rst) begin
            drop_cnt <= '0;
        end else if (log_we && !accept && drop_cnt != '1) begin
            drop_cnt <= drop_cnt + 1'b1;
        end
    end

    // ------------------------------
    // Read bank select
    // ------------------------------

    // Same retime as inside each bank
    always_ff @(posedge rd_clk) begin
        rd_rst_pipe <= {rd_rst_pipe[0], rst};
    end

    assign rd_rst  = rd_rst_pipe[1];
    assign rd_rdy  = (rd_bank == BANK0) ? buf0_rd_full : buf1_rd_full;
    assign pop     = rd_en && rd_rdy;
    assign buf0_re = pop && (rd_bank == BANK0);
    assign buf1_re = pop && (rd_bank == BANK1);

    always_ff @(posedge rd_clk) begin
        if (rd_rst) begin
            rd_bank   <= BANK0;
            dout_bank <= BANK0;
            rd_rdy_q  <= 1'b0;
        end else begin
            rd_rdy_q <= rd_rdy;
            // Bank of the word now on dout
            if (pop) begin
                dout_bank <= rd_bank;
            end
            // Drained, move on to the other bank
            if (rd_rdy_q && !rd_rdy) begin
                rd_bank <= (rd_bank == BANK0) ? BANK1 : BANK0;
            end
        end
    end

    assign dout = (dout_bank == BANK0) ? buf0_dout : buf1_dout;

    log_buffer buf0_i (
        .wr_clk   (wr_clk),
        .rd_clk   (rd_clk),
        .rst      (rst),
        .we       (buf0_we),
        .din      (log_word),
        .re       (buf0_re),
        .dout     (buf0_dout),
        .wr_full  (buf0_wr_full),
        .wr_empty (buf0_wr_empty),
        .rd_full  (buf0_rd_full)
    );

    log_buffer buf1_i (
        .wr_clk   (wr_clk),
        .rd_clk   (rd_clk),
        .rst      (rst),
        .we       (buf1_we),
        .din      (log_word),
        .re       (buf1_re),
        .dout     (buf1_dout),
        .wr_full  (buf1_wr_full),
        .wr_empty (buf1_wr_empty),
        .rd_full  (buf1_rd_full)
    );

endmodule

/* verilog/log_framer.sv */
`timescale 1ns/100ps

module log_framer
    import log_pkg::*;
(
    input  logic  wr_clk,
    input  logic  rst,
    input  logic  sample_valid,
    input  word_t sample,
    output logic  log_we,
    output word_t log_word
);

    // Index of the last channel in a frame
    localparam chan_t LAST_CHAN = chan_t'(FRAME_LEN - 2);

    framer_state_t state;
    chan_t         chan;
    seq_t          seq;
    word_t         hold;

    // ------------------------------
    // Control FSM
    // ------------------------------

    always_ff @(posedge wr_clk) begin
        if (rst) begin
            state  <= FR_IDLE;
            chan   <= '0;
            seq    <= '0;
            log_we <= 1'b0;
        end else begin
            log_we <= 1'b0;
            case (state)
                // Channel 0 opens a frame, header goes out first
                FR_IDLE: begin
                    if (sample_valid) begin
                        log_we <= 1'b1;
                        chan   <= chan + 1'b1;
                        seq    <= seq + 1'b1;
                        state  <= FR_HOLD;
                    end
                end
                // Held channel 0 sample
                FR_HOLD: begin
                    log_we <= 1'b1;
                    state  <= FR_SAMPLE;
                end
                FR_SAMPLE: begin
                    if (sample_valid) begin
                        log_we <= 1'b1;
                        if (chan == LAST_CHAN) begin
                            chan  <= '0;
                            state <= FR_IDLE;
                        end else begin
                            chan <= chan + 1'b1;
                        end
                    end
                end
                default: state <= FR_IDLE;
            endcase
        end
    end

    // ------------------------------
    // Data path
    // ------------------------------

    always_ff @(posedge wr_clk) begin
        case (state)
            FR_IDLE: begin
                if (sample_valid) begin
                    log_word <= word_t'({HDR_MARK, seq});
                    hold     <= sample;
                end
            end
            FR_HOLD: log_word <= hold;
            FR_SAMPLE: begin
                if (sample_valid) begin
                    log_word <= sample;
                end
            end
            default: ;
        endcase
    end

endmodule

/* verilog/adc_log_top.sv */
`timescale 1ns/100ps

module adc_log_top
    import log_pkg::*, buf_pkg::*;
(
    input  logic      wr_clk,
    input  logic      rd_clk,
    input  logic      rst,
    input  logic      sample_valid,
    input  word_t     sample,
    input  logic      rd_en,
    output logic      rd_rdy,
    output word_t     dout,
    output drop_cnt_t drop_cnt
);

    // Framed stream into the ping-pong buffer
    logic  log_we;
    word_t log_word;

    log_framer framer_i (
        .wr_clk       (wr_clk),
        .rst          (rst),
        .sample_valid (sample_valid),
        .sample       (sample),
        .log_we       (log_we),
        .log_word     (log_word)
    );

    dual_log_fifo fifo_i (
        .wr_clk   (wr_clk),
        .rd_clk   (rd_clk),
        .rst      (rst),
        .log_we   (log_we),
        .log_word (log_word),
        .rd_en    (rd_en),
        .rd_rdy   (rd_rdy),
        .dout     (dout),
        .drop_cnt (drop_cnt)
    );

endmodule

/* sim/adc_log_assert.sv */
`timescale 1ns/100ps

module adc_log_assert
    import buf_pkg::*;
(
    input logic      wr_clk,
    input logic      rd_clk,
    input logic      rst,
    input logic      sample_valid,
    input logic      rd_en,
    input logic      rd_rdy,
    input drop_cnt_t drop_cnt
);

    // Count of failed assertions
    int fail_cnt = 0;

    // ------------------------------
    // Host side
    // ------------------------------

    // Pops only while a complete block is offered
    a_rd_en_rdy: assert property (
        @(posedge rd_clk) disable iff (rst) rd_en |-> rd_rdy
    ) else begin
        fail_cnt++;
        $error("rd_en high while rd_rdy is low");
    end

    // ------------------------------
    // Write side
    // ------------------------------

    // Header and sample share one write port
    a_sample_gap: assert property (
        @(posedge wr_clk) disable iff (rst) sample_valid |=> !sample_valid
    ) else begin
        fail_cnt++;
        $error("sample_valid high on two cycles in a row");
    end

    // Saturating counter, never goes back
    a_drop_mono: assert property (
        @(posedge wr_clk) disable iff (rst) drop_cnt >= $past(drop_cnt)
    ) else begin
        fail_cnt++;
        $error("drop_cnt decreased");
    end

endmodule

bind adc_log_top adc_log_assert assert_i (
    .wr_clk       (wr_clk),
    .rd_clk       (rd_clk),
    .rst          (rst),
    .sample_valid (sample_valid),
    .rd_en        (rd_en),
    .rd_rdy       (rd_rdy),
    .drop_cnt     (drop_cnt)
);

/* sim/adc_log_tb.sv */
`timescale 1ns/100ps

module adc_log_tb
    import log_pkg::*, buf_pkg::*;
();

    // ------------------------------
    // Stimulus table
    // ------------------------------

    // Frames to send, read while sending, drop count after the step
    typedef struct packed {
        logic [7:0] frames;
        logic       read;
        drop_cnt_t  drops;
    } step_t;

    localparam int N_STEPS = 5;

    step_t     steps [N_STEPS];

    // DUT ports
    logic      wr_clk;
    logic      rd_clk;
    logic      rst;
    logic      sample_valid;
    word_t     sample;
    logic      rd_en;
    logic      rd_rdy;
    word_t     dout;
    drop_cnt_t drop_cnt;

    integer    seed;
    int        cycles = 0;
    int        cycle_limit;

    // Reference model state
    word_t     exp_q [$];
    int        fill;
    int        full_blocks;
    seq_t      seq_exp;

    adc_log_top dut_i (
        .wr_clk       (wr_clk),
        .rd_clk       (rd_clk),
        .rst          (rst),
        .sample_valid (sample_valid),
        .sample       (sample),
        .rd_en        (rd_en),
        .rd_rdy       (rd_rdy),
        .dout         (dout),
        .drop_cnt     (drop_cnt)
    );

    // 8 ns write clock
    initial begin
        wr_clk = 1'b0;
        forever #4 wr_clk = ~wr_clk;
    end

    // 10 ns host clock
    initial begin
        rd_clk = 1'b0;
        forever #5 rd_clk = ~rd_clk;
    end

    // ------------------------------
    // Compare tasks
    // ------------------------------

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: %s = 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_drop(input string name, input drop_cnt_t got, input drop_cnt_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: %s = 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: %s = 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // ------------------------------
    // Model, writer and reader
    // ------------------------------

    // One framer word into the model
    task automatic push_model(input word_t w);
        if (fill == 0 && full_blocks == 2) begin
            // Word lost while both banks hold unread blocks
        end else begin
            exp_q.push_back(w);
            fill++;
            // Write side moves to the other bank on a complete block
            if (fill == BUF_DEPTH) begin
                fill = 0;
                full_blocks++;
            end
        end
    endtask

    task automatic send_frames(input int n);
        word_t smp;
        int    gap;
        for (int f = 0; f < n; f++) begin
            // Header goes out ahead of channel 0
            push_model(word_t'({HDR_MARK, seq_exp}));
            seq_exp++;
            for (int c = 0; c < N_ADC; c++) begin
                smp = word_t'($random(seed));
                gap = 1 + ({$random(seed)} % 3);
                push_model(smp);
                sample_valid = 1'b1;
                sample       = smp;
                @(negedge wr_clk);
                sample_valid = 1'b0;
                // 1 to 3 idle cycles
                repeat (gap) @(negedge wr_clk);
            end
            // Nothing offered before the first complete block
            if (full_blocks == 0) begin
                check_flag("rd_rdy", rd_rdy, 1'b0);
            end
        end
    endtask

    task automatic read_blocks(input int n);
        for (int b = 0; b < n; b++) begin
            @(negedge rd_clk);
            while (rd_rdy !== 1'b1) begin
                @(negedge rd_clk);
            end
            // Back to back pops through the whole block
            rd_en = 1'b1;
            for (int i = 0; i < BUF_DEPTH; i++) begin
                check_flag("rd_rdy", rd_rdy, 1'b1);
                @(negedge rd_clk);
                check_word("dout", dout, exp_q.pop_front());
            end
            rd_en = 1'b0;
            // Last pop drops rd_rdy on the same edge
            check_flag("rd_rdy", rd_rdy, 1'b0);
            full_blocks--;
        end
    endtask

    // ------------------------------
    // Timeout
    // ------------------------------

    always @(posedge wr_clk) begin
        cycles++;
        if (cycles == cycle_limit) begin
            fail_run($sformatf("Timeout after %0d wr_clk cycles", cycles));
        end
    end

    // Bound checker
    always @(dut_i.assert_i.fail_cnt) begin
        if (dut_i.assert_i.fail_cnt != 0) begin
            fail_run("An assertion in the bound checker failed");
        end
    end

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        int total_frames;
        int n_blocks;

        seed         = 32'h730e25dc;
        rst          = 1'b1;
        sample_valid = 1'b0;
        sample       = '0;
        rd_en        = 1'b0;
        fill         = 0;
        full_blocks  = 0;
        seq_exp      = '0;

        // Overflow, drain, ping-pong after recovery, one more block, drain
        steps[0] = '{8'd7, 1'b0, 16'd17};
        steps[1] = '{8'd0, 1'b1, 16'd17};
        steps[2] = '{8'd5, 1'b1, 16'd17};
        steps[3] = '{8'd2, 1'b0, 16'd17};
        steps[4] = '{8'd0, 1'b1, 16'd17};

        total_frames = 0;
        for (int s = 0; s < N_STEPS; s++) begin
            total_frames += steps[s].frames;
        end
        cycle_limit = 200 * total_frames + 500;

        repeat (2) @(posedge wr_clk);
        @(negedge wr_clk);
        rst = 1'b0;
        // Retimed reset in rd_clk runs out
        repeat (4) @(negedge rd_clk);
        @(negedge wr_clk);
        check_flag("rd_rdy", rd_rdy, 1'b0);
        check_drop("drop_cnt", drop_cnt, '0);
        check_word("dout", dout, '0);

        for (int s = 0; s < N_STEPS; s++) begin
            // Blocks complete by the end of the step
            n_blocks = full_blocks + (fill + steps[s].frames * FRAME_LEN) / BUF_DEPTH;
            if (steps[s].read) begin
                fork
                    send_frames(steps[s].frames);
                    read_blocks(n_blocks);
                join
            end else begin
                send_frames(steps[s].frames);
            end
            // Framer pipeline and pointer sync settle
            repeat (10) @(negedge wr_clk);
            check_drop("drop_cnt", drop_cnt, steps[s].drops);
            check_flag("rd_rdy", rd_rdy, logic'(full_blocks != 0));
        end

        if (dut_i.assert_i.fail_cnt == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            fail_run($sformatf("%0d assertion failures", dut_i.assert_i.fail_cnt));
        end
    end

endmodule

/* verilog.f */
verilog/log_pkg.sv
verilog/buf_pkg.sv
verilog/log_buffer.sv
verilog/dual_log_fifo.sv
verilog/log_framer.sv
verilog/adc_log_top.sv
sim/adc_log_assert.sv
sim/adc_log_tb.sv

/* Bender.yml */
package:
  name: adc_log

sources:
  # RTL, packages first
  - verilog/log_pkg.sv
  - verilog/buf_pkg.sv
  - verilog/log_buffer.sv
  - verilog/dual_log_fifo.sv
  - verilog/log_framer.sv
  - verilog/adc_log_top.sv

  # Testbench and bound assertions
  - target: simulation
    files:
      - sim/adc_log_assert.sv
      - sim/adc_log_tb.sv
